// ==== rvv_div_cfg_pkg.sv ====
package rvv_div_cfg_pkg;

  // vector register geometry
  localparam int vlen  = 64;
  localparam int vlenb = vlen / 8;

  localparam int byte_width  = 8;
  localparam int hword_width = 16;
  localparam int word_width  = 32;

  // lower half of the bytes in 8-bit lanes
  localparam int lanes8  = vlenb / 2;
  // next quarter in 16-bit lanes
  localparam int lanes16 = vlenb / 4;
  // top quarter in 32-bit lanes, also covers a full EEW32 register
  localparam int lanes32 = vlen / word_width;

  localparam int rob_idx_width = 3;

  typedef logic [vlen-1:0]          vreg_t;
  typedef logic [word_width-1:0]    xreg_t;
  typedef logic [rob_idx_width-1:0] rob_idx_t;

endpackage

// ==== rvv_div_uop_pkg.sv ====
package rvv_div_uop_pkg;

  import rvv_div_cfg_pkg::*;

  typedef enum logic [2:0] {
    opmvv = 3'b010,
    opmvx = 3'b110
  } funct3_e;

  typedef enum logic [5:0] {
    vdivu = 6'b100000,
    vdiv  = 6'b100001,
    vremu = 6'b100010,
    vrem  = 6'b100011
  } funct6_e;

  typedef enum logic [1:0] {
    eew8  = 2'b00,
    eew16 = 2'b01,
    eew32 = 2'b10
  } eew_e;

  // one reservation station entry
  typedef struct packed {
    rob_idx_t rob_entry;
    funct6_e  funct6;
    funct3_e  funct3;
    vreg_t    vs1_data;
    logic     vs1_data_valid;
    vreg_t    vs2_data;
    logic     vs2_data_valid;
    eew_e     vs2_eew;
    xreg_t    rs1_data;
    logic     rs1_data_valid;
  } div_uop_t;

  typedef struct packed {
    logic is_rem;
    eew_e eew;
  } div_ctrl_t;

  // src2 is the dividend, src1 the divisor
  typedef struct packed {
    logic [lanes8-1:0][byte_width-1:0]   src2_8;
    logic [lanes8-1:0][byte_width-1:0]   src1_8;
    logic [lanes16-1:0][hword_width-1:0] src2_16;
    logic [lanes16-1:0][hword_width-1:0] src1_16;
    logic [lanes32-1:0][word_width-1:0]  src2_32;
    logic [lanes32-1:0][word_width-1:0]  src1_32;
  } div_operands_t;

  typedef struct packed {
    logic [lanes8-1:0][byte_width-1:0]   quo_8;
    logic [lanes8-1:0][byte_width-1:0]   rem_8;
    logic [lanes16-1:0][hword_width-1:0] quo_16;
    logic [lanes16-1:0][hword_width-1:0] rem_16;
    logic [lanes32-1:0][word_width-1:0]  quo_32;
    logic [lanes32-1:0][word_width-1:0]  rem_32;
  } div_lane_results_t;

  // to the reorder buffer
  typedef struct packed {
    rob_idx_t rob_entry;
    vreg_t    w_data;
  } div_result_t;

endpackage

// ==== rvv_div_operand_prep.sv ====
`timescale 1ns/100ps

module rvv_div_operand_prep (
  input  logic                           div_uop_valid,
  input  rvv_div_uop_pkg::div_uop_t      div_uop,
  output logic                           start,
  output logic                           is_signed,
  output rvv_div_uop_pkg::div_ctrl_t     ctrl,
  output rvv_div_uop_pkg::div_operands_t operands
);

  import rvv_div_cfg_pkg::*;
  import rvv_div_uop_pkg::*;

  logic is_div_op;
  logic is_vx;
  logic src_valid;

  // element idx of a register, right aligned, upper bits zero
  function automatic xreg_t get_elem(input vreg_t v, input int idx, input eew_e eew);
    xreg_t raw;
    raw = '0;
    case (eew)
      eew8:    raw[byte_width-1:0]  = v[idx*byte_width +: byte_width];
      eew16:   raw[hword_width-1:0] = v[idx*hword_width +: hword_width];
      default: raw = v[idx*word_width +: word_width];
    endcase
    return raw;
  endfunction

  function automatic xreg_t extend(input xreg_t raw, input eew_e eew, input logic sgn);
    xreg_t ext;
    case (eew)
      eew8:    ext = {{(word_width-byte_width){sgn & raw[byte_width-1]}},
                      raw[byte_width-1:0]};
      eew16:   ext = {{(word_width-hword_width){sgn & raw[hword_width-1]}},
                      raw[hword_width-1:0]};
      default: ext = raw;
    endcase
    return ext;
  endfunction

  // vector-scalar forms broadcast rs1 to every element
  function automatic xreg_t src_elem(input vreg_t v, input int idx, input logic use_rs1);
    xreg_t raw;
    raw = use_rs1 ? div_uop.rs1_data : get_elem(v, idx, div_uop.vs2_eew);
    return extend(raw, div_uop.vs2_eew, is_signed);
  endfunction

  always_comb begin
    case (div_uop.funct6)
      vdivu, vdiv, vremu, vrem: is_div_op = 1'b1;
      default:                  is_div_op = 1'b0;
    endcase
  end

  always_comb begin
    case (div_uop.funct3)
      opmvv:   src_valid = div_uop.vs2_data_valid & div_uop.vs1_data_valid;
      opmvx:   src_valid = div_uop.vs2_data_valid & div_uop.rs1_data_valid;
      default: src_valid = 1'b0;
    endcase
  end

  assign is_vx       = (div_uop.funct3 == opmvx);
  assign start       = div_uop_valid & is_div_op & src_valid;
  assign is_signed   = (div_uop.funct6 == vdiv) || (div_uop.funct6 == vrem);
  assign ctrl.is_rem = (div_uop.funct6 == vremu) || (div_uop.funct6 == vrem);
  assign ctrl.eew    = div_uop.vs2_eew;

  // spread elements over the lanes, low elements to the narrowest lanes
  always_comb begin
    xreg_t e1;
    xreg_t e2;
    operands = '0;
    e1 = '0;
    e2 = '0;
    case (div_uop.vs2_eew)
      eew8: begin
        for (int i = 0; i < lanes8; i++) begin
          e2 = src_elem(div_uop.vs2_data, i, 1'b0);
          e1 = src_elem(div_uop.vs1_data, i, is_vx);
          operands.src2_8[i] = e2[byte_width-1:0];
          operands.src1_8[i] = e1[byte_width-1:0];
        end
        for (int i = 0; i < lanes16; i++) begin
          e2 = src_elem(div_uop.vs2_data, lanes8 + i, 1'b0);
          e1 = src_elem(div_uop.vs1_data, lanes8 + i, is_vx);
          operands.src2_16[i] = e2[hword_width-1:0];
          operands.src1_16[i] = e1[hword_width-1:0];
        end
        for (int i = 0; i < lanes32; i++) begin
          operands.src2_32[i] = src_elem(div_uop.vs2_data, lanes8 + lanes16 + i, 1'b0);
          operands.src1_32[i] = src_elem(div_uop.vs1_data, lanes8 + lanes16 + i, is_vx);
        end
      end
      eew16: begin
        for (int i = 0; i < lanes16; i++) begin
          e2 = src_elem(div_uop.vs2_data, i, 1'b0);
          e1 = src_elem(div_uop.vs1_data, i, is_vx);
          operands.src2_16[i] = e2[hword_width-1:0];
          operands.src1_16[i] = e1[hword_width-1:0];
        end
        for (int i = 0; i < lanes32; i++) begin
          operands.src2_32[i] = src_elem(div_uop.vs2_data, lanes16 + i, 1'b0);
          operands.src1_32[i] = src_elem(div_uop.vs1_data, lanes16 + i, is_vx);
        end
      end
      eew32: begin
        for (int i = 0; i < lanes32; i++) begin
          operands.src2_32[i] = src_elem(div_uop.vs2_data, i, 1'b0);
          operands.src1_32[i] = src_elem(div_uop.vs1_data, i, is_vx);
        end
      end
      default: ;
    endcase
  end

endmodule

// ==== rvv_div_divider.sv ====
`timescale 1ns/100ps

module rvv_div_divider #(
  parameter type elem_t = logic [7:0]
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  start,
  input  logic  is_signed,
  input  logic  accept,
  input  elem_t dividend,
  input  elem_t divisor,
  output elem_t quotient,
  output elem_t remainder,
  output logic  done
);

  localparam int w         = $bits(elem_t);
  localparam int cnt_width = $clog2(w + 1);
  localparam logic [cnt_width-1:0] last_step = cnt_width'(w);

  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_done
  } state_e;

  state_e               state;
  logic [cnt_width-1:0] step;

  // dividend bits shift out of quo while quotient bits shift in
  logic [w-1:0] quo;
  logic [w-1:0] rem;
  logic [w-1:0] dvs;
  logic         neg_quo;
  logic         neg_rem;
  logic         div_zero;

  logic         sign_a;
  logic         sign_b;
  logic [w:0]   partial;
  logic [w:0]   trial;

  assign sign_a  = is_signed & dividend[w-1];
  assign sign_b  = is_signed & divisor[w-1];
  assign partial = {rem, quo[w-1]};
  assign trial   = partial - {1'b0, dvs};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_idle;
      step  <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state <= st_run;
            step  <= '0;
          end
        end
        st_run: begin
          step <= step + 1'b1;
          if (step == last_step) begin
            state <= st_done;
          end
        end
        st_done: begin
          if (accept) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      st_idle: begin
        if (start) begin
          quo      <= sign_a ? -dividend : dividend;
          dvs      <= sign_b ? -divisor : divisor;
          rem      <= '0;
          neg_quo  <= sign_a ^ sign_b;
          neg_rem  <= sign_a;
          div_zero <= (divisor == '0);
        end
      end
      st_run: begin
        if (step == last_step) begin
          // sign fix; remainder follows the dividend
          // most negative / -1 lands on the dividend without help
          quo <= div_zero ? '1 : (neg_quo ? -quo : quo);
          rem <= neg_rem ? -rem : rem;
        end else if (trial[w]) begin
          quo <= {quo[w-2:0], 1'b0};
          rem <= partial[w-1:0];
        end else begin
          quo <= {quo[w-2:0], 1'b1};
          rem <= trial[w-1:0];
        end
      end
      default: ;
    endcase
  end

  assign quotient  = quo;
  assign remainder = rem;
  assign done      = (state == st_done);

endmodule

// ==== rvv_div_result_merge.sv ====
`timescale 1ns/100ps

module rvv_div_result_merge (
  input  logic                               start,
  input  rvv_div_uop_pkg::div_ctrl_t         ctrl,
  input  rvv_div_cfg_pkg::rob_idx_t          rob_entry,
  input  rvv_div_uop_pkg::div_lane_results_t lane_results,
  input  logic [rvv_div_cfg_pkg::lanes8-1:0]  done8,
  input  logic [rvv_div_cfg_pkg::lanes16-1:0] done16,
  input  logic [rvv_div_cfg_pkg::lanes32-1:0] done32,
  input  logic                               result_ready,
  output logic                               result_valid,
  output rvv_div_uop_pkg::div_result_t       result,
  output logic                               accept
);

  import rvv_div_cfg_pkg::*;
  import rvv_div_uop_pkg::*;

  logic                                all_done;
  vreg_t                               w_data;
  logic [lanes8-1:0][byte_width-1:0]   pick8;
  logic [lanes16-1:0][hword_width-1:0] pick16;
  logic [lanes32-1:0][word_width-1:0]  pick32;

  // lanes in use for this element width
  always_comb begin
    case (ctrl.eew)
      eew8:    all_done = &{done8, done16, done32};
      eew16:   all_done = &{done16, done32};
      eew32:   all_done = &done32;
      default: all_done = 1'b0;
    endcase
  end

  assign pick8  = ctrl.is_rem ? lane_results.rem_8  : lane_results.quo_8;
  assign pick16 = ctrl.is_rem ? lane_results.rem_16 : lane_results.quo_16;
  assign pick32 = ctrl.is_rem ? lane_results.rem_32 : lane_results.quo_32;

  // back to element order, wide lanes cut down to the element width
  always_comb begin
    w_data = '0;
    case (ctrl.eew)
      eew8: begin
        for (int i = 0; i < lanes8; i++) begin
          w_data[i*byte_width +: byte_width] = pick8[i];
        end
        for (int i = 0; i < lanes16; i++) begin
          w_data[(lanes8+i)*byte_width +: byte_width] = pick16[i][byte_width-1:0];
        end
        for (int i = 0; i < lanes32; i++) begin
          w_data[(lanes8+lanes16+i)*byte_width +: byte_width] = pick32[i][byte_width-1:0];
        end
      end
      eew16: begin
        for (int i = 0; i < lanes16; i++) begin
          w_data[i*hword_width +: hword_width] = pick16[i];
        end
        for (int i = 0; i < lanes32; i++) begin
          w_data[(lanes16+i)*hword_width +: hword_width] = pick32[i][hword_width-1:0];
        end
      end
      eew32: begin
        for (int i = 0; i < lanes32; i++) begin
          w_data[i*word_width +: word_width] = pick32[i];
        end
      end
      default: ;
    endcase
  end

  assign result_valid     = start & all_done;
  assign accept           = result_valid & result_ready;
  assign result.rob_entry = rob_entry;
  assign result.w_data    = w_data;

endmodule

// ==== rvv_div_unit.sv ====
`timescale 1ns/100ps

module rvv_div_unit (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         div_uop_valid,
  input  rvv_div_uop_pkg::div_uop_t    div_uop,
  output logic                         result_valid,
  output rvv_div_uop_pkg::div_result_t result,
  input  logic                         result_ready
);

  import rvv_div_cfg_pkg::*;
  import rvv_div_uop_pkg::*;

  logic              start;
  logic              is_signed;
  logic              accept;
  div_ctrl_t         ctrl;
  div_operands_t     operands;
  div_lane_results_t lane_results;
  logic [lanes8-1:0]  done8;
  logic [lanes16-1:0] done16;
  logic [lanes32-1:0] done32;

  genvar j;

  rvv_div_operand_prep u_prep (
    .div_uop_valid (div_uop_valid),
    .div_uop       (div_uop),
    .start         (start),
    .is_signed     (is_signed),
    .ctrl          (ctrl),
    .operands      (operands)
  );

  generate
    for (j = 0; j < lanes8; j++) begin : g_div8
      rvv_div_divider #(
        .elem_t (logic [byte_width-1:0])
      ) u_div (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .is_signed (is_signed),
        .accept    (accept),
        .dividend  (operands.src2_8[j]),
        .divisor   (operands.src1_8[j]),
        .quotient  (lane_results.quo_8[j]),
        .remainder (lane_results.rem_8[j]),
        .done      (done8[j])
      );
    end

    for (j = 0; j < lanes16; j++) begin : g_div16
      rvv_div_divider #(
        .elem_t (logic [hword_width-1:0])
      ) u_div (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .is_signed (is_signed),
        .accept    (accept),
        .dividend  (operands.src2_16[j]),
        .divisor   (operands.src1_16[j]),
        .quotient  (lane_results.quo_16[j]),
        .remainder (lane_results.rem_16[j]),
        .done      (done16[j])
      );
    end

    // slowest lanes, these set the latency for every element width
    for (j = 0; j < lanes32; j++) begin : g_div32
      rvv_div_divider #(
        .elem_t (logic [word_width-1:0])
      ) u_div (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .is_signed (is_signed),
        .accept    (accept),
        .dividend  (operands.src2_32[j]),
        .divisor   (operands.src1_32[j]),
        .quotient  (lane_results.quo_32[j]),
        .remainder (lane_results.rem_32[j]),
        .done      (done32[j])
      );
    end
  endgenerate

  rvv_div_result_merge u_merge (
    .start        (start),
    .ctrl         (ctrl),
    .rob_entry    (div_uop.rob_entry),
    .lane_results (lane_results),
    .done8        (done8),
    .done16       (done16),
    .done32       (done32),
    .result_ready (result_ready),
    .result_valid (result_valid),
    .result       (result),
    .accept       (accept)
  );

endmodule

// ==== rvv_div_tb_vectors.svh ====
`ifndef RVV_DIV_TB_VECTORS_SVH
`define RVV_DIV_TB_VECTORS_SVH

// rob, funct6, funct3, eew, vs2, vs1, rs1, legal, expected w_data
task automatic load_table();
  add_vec(3'd0, 6'b100100, opmvv, eew8, 64'h0102_0304_0506_0708,
          64'h0101_0101_0101_0101, 32'h0000_0001, 1'b0, 64'h0);
  add_vec(3'd1, vdivu, opmvv, eew8, 64'h63F0_11FA_C807_FF64,
          64'h0A0D_050A_0309_1007, 32'h0, 1'b1, 64'h0912_0319_4200_0F0E);
  add_vec(3'd2, vremu, opmvv, eew8, 64'h63F0_11FA_C807_FF64,
          64'h0A0D_050A_0309_1007, 32'h0, 1'b1, 64'h0906_0200_0207_0F02);
  add_vec(3'd3, vdivu, opmvv, eew16, 64'h1234_C350_03E8_FFFF,
          64'h0010_00FA_0007_0100, 32'h0, 1'b1, 64'h0123_00C8_008E_00FF);
  add_vec(3'd4, vremu, opmvv, eew16, 64'h1234_C350_03E8_FFFF,
          64'h0010_00FA_0007_0100, 32'h0, 1'b1, 64'h0004_0000_0006_00FF);
  add_vec(3'd5, vdivu, opmvv, eew32, 64'h000F_4240_FFFF_FFFF,
          64'h0000_0003_0001_0000, 32'h0, 1'b1, 64'h0005_1615_0000_FFFF);
  add_vec(3'd6, vremu, opmvv, eew32, 64'h000F_4240_FFFF_FFFF,
          64'h0000_0003_0001_0000, 32'h0, 1'b1, 64'h0000_0001_0000_FFFF);
  // OPIVV funct3 is not handled here
  add_vec(3'd7, vdiv, 3'b000, eew16, 64'h0010_0020_0030_0040,
          64'h0002_0002_0002_0002, 32'h2, 1'b0, 64'h0);
  // elements 6 and 7 run in the 32-bit lanes, element 6 overflows
  add_vec(3'd7, vdiv, opmvv, eew8, 64'h8080_649C_07F9_07F9,
          64'h03FF_F907_02FE_FE02, 32'h0, 1'b1, 64'hD680_F2F2_0303_FDFD);
  add_vec(3'd0, vrem, opmvv, eew8, 64'h8080_649C_07F9_07F9,
          64'h03FF_F907_02FE_FE02, 32'h0, 1'b1, 64'hFE00_02FE_01FF_01FF);
  add_vec(3'd1, vdiv, opmvv, eew16, 64'h3039_8000_7530_FC18,
          64'hFF9C_FFFF_FED4_0007, 32'h0, 1'b1, 64'hFF85_8000_FF9C_FF72);
  add_vec(3'd2, vrem, opmvv, eew16, 64'h3039_8000_7530_FC18,
          64'hFF9C_FFFF_FED4_0007, 32'h0, 1'b1, 64'h002D_0000_0000_FFFA);
  add_vec(3'd3, vdiv, opmvv, eew32, 64'hFFF0_BDC0_8000_0000,
          64'h0000_0007_FFFF_FFFF, 32'h0, 1'b1, 64'hFFFD_D1F7_8000_0000);
  add_vec(3'd4, vrem, opmvv, eew32, 64'hFFF0_BDC0_8000_0000,
          64'h0000_0007_FFFF_FFFF, 32'h0, 1'b1, 64'hFFFF_FFFF_0000_0000);
  // scalar forms, vs1 holds junk that must be ignored
  add_vec(3'd5, vdivu, opmvx, eew8, 64'h33AA_5500_7FFF_8001,
          64'hDEAD_BEEF_0BAD_F00D, 32'h1234_5600, 1'b1, 64'hFFFF_FFFF_FFFF_FFFF);
  add_vec(3'd6, vremu, opmvx, eew8, 64'h33AA_5500_7FFF_8001,
          64'hDEAD_BEEF_0BAD_F00D, 32'hFFFF_FF00, 1'b1, 64'h33AA_5500_7FFF_8001);
  add_vec(3'd7, vdiv, opmvx, eew16, 64'h8000_7FFF_FF9C_0064,
          64'h0101_0101_0101_0101, 32'hABCD_FFF9, 1'b1, 64'h1249_EDB7_000E_FFF2);
  add_vec(3'd0, vrem, opmvx, eew32, 64'hFFFF_FFF6_8000_0000,
          64'h0000_0005_0000_0005, 32'h0000_0000, 1'b1, 64'hFFFF_FFF6_8000_0000);
  add_vec(3'd1, vdiv, opmvx, eew32, 64'hFFFF_FFF6_8000_0000,
          64'h0000_0005_0000_0005, 32'hFFFF_FFFF, 1'b1, 64'h0000_000A_8000_0000);
endtask

`endif

// ==== rvv_div_unit_tb.sv ====
`timescale 1ns/100ps

module rvv_div_unit_tb;

  import rvv_div_cfg_pkg::*;
  import rvv_div_uop_pkg::*;

  localparam int clk_period        = 4;
  localparam int reset_cycles      = 4;
  localparam int idle_check_cycles = 40;

  // one table row with stimulus and expected write data
  typedef struct packed {
    rob_idx_t   rob_entry;
    logic [5:0] funct6;
    logic [2:0] funct3;
    eew_e       eew;
    vreg_t      vs2;
    vreg_t      vs1;
    xreg_t      rs1;
    logic       legal;
    vreg_t      exp_data;
  } test_vec_t;

  logic        clk;
  logic        rst_n;
  logic        div_uop_valid;
  div_uop_t    div_uop;
  logic        result_valid;
  div_result_t result;
  logic        result_ready;

  test_vec_t   tests[$];
  int          cycle_count = 0;
  int          cycle_limit = 0;

  function automatic void add_vec(input rob_idx_t rob, input logic [5:0] f6,
                                  input logic [2:0] f3, input eew_e eew, input vreg_t vs2,
                                  input vreg_t vs1, input xreg_t rs1, input logic legal,
                                  input vreg_t exp_data);
    test_vec_t t;
    t.rob_entry = rob;
    t.funct6    = f6;
    t.funct3    = f3;
    t.eew       = eew;
    t.vs2       = vs2;
    t.vs1       = vs1;
    t.rs1       = rs1;
    t.legal     = legal;
    t.exp_data  = exp_data;
    tests.push_back(t);
  endfunction

  `include "rvv_div_tb_vectors.svh"

  rvv_div_unit UUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .div_uop_valid (div_uop_valid),
    .div_uop       (div_uop),
    .result_valid  (result_valid),
    .result        (result),
    .result_ready  (result_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("FAIL %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_result(input string name, input div_result_t got,
                              input div_result_t exp);
    if (got.rob_entry !== exp.rob_entry) begin
      report_failure($sformatf("FAIL %s.rob_entry: got %h expected %h",
                               name, got.rob_entry, exp.rob_entry));
    end
    if (got.w_data !== exp.w_data) begin
      report_failure($sformatf("FAIL %s.w_data: got %h expected %h",
                               name, got.w_data, exp.w_data));
    end
  endtask

  function automatic div_uop_t build_uop(input test_vec_t t);
    div_uop_t u;
    u.rob_entry      = t.rob_entry;
    u.funct6         = funct6_e'(t.funct6);
    u.funct3         = funct3_e'(t.funct3);
    u.vs1_data       = t.vs1;
    u.vs1_data_valid = 1'b1;
    u.vs2_data       = t.vs2;
    u.vs2_data_valid = 1'b1;
    u.vs2_eew        = t.eew;
    u.rs1_data       = t.rs1;
    u.rs1_data_valid = 1'b1;
    return u;
  endfunction

  // drive one uop, then hold the result back for a few cycles before taking it
  task automatic run_entry(input test_vec_t t);
    div_result_t expected;
    int          hold;
    expected.rob_entry = t.rob_entry;
    expected.w_data    = t.exp_data;
    @(posedge clk);
    div_uop       <= build_uop(t);
    div_uop_valid <= 1'b1;
    result_ready  <= 1'b0;
    @(negedge clk);
    check_bit("result_valid", result_valid, 1'b0);
    if (!t.legal) begin
      repeat (idle_check_cycles) begin
        @(negedge clk);
        check_bit("result_valid", result_valid, 1'b0);
      end
    end else begin
      while (result_valid !== 1'b1) begin
        @(negedge clk);
      end
      check_result("result", result, expected);
      hold = $urandom % 4;
      repeat (hold) begin
        @(negedge clk);
        check_bit("result_valid", result_valid, 1'b1);
        check_result("result", result, expected);
      end
      @(posedge clk);
      result_ready <= 1'b1;
      @(negedge clk);
      check_bit("result_valid", result_valid, 1'b1);
      check_result("result", result, expected);
    end
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      report_failure($sformatf("timeout after %0d cycles without finishing the table",
                               cycle_count));
    end
  end

  initial begin
    int unsigned seed;
    int unsigned discard;
    seed          = 32'h216f_87dd;
    discard       = $urandom(seed);
    rst_n         = 1'b0;
    div_uop_valid = 1'b0;
    div_uop       = '0;
    result_ready  = 1'b0;
    load_table();
    cycle_limit = tests.size() * 45 + 100;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_bit("result_valid", result_valid, 1'b0);
    foreach (tests[i]) begin
      run_entry(tests[i]);
    end
    // the last accept edge ends the table
    @(posedge clk);
    div_uop_valid <= 1'b0;
    result_ready  <= 1'b0;
    @(negedge clk);
    check_bit("result_valid", result_valid, 1'b0);
    $display("All tests passed");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+.
rvv_div_cfg_pkg.sv
rvv_div_uop_pkg.sv
rvv_div_operand_prep.sv
rvv_div_divider.sv
rvv_div_result_merge.sv
rvv_div_unit.sv
rvv_div_unit_tb.sv
